//--- rtl/quad_ctrl_config.svh
`ifndef QUAD_CTRL_CONFIG_SVH
`define QUAD_CTRL_CONFIG_SVH

////////////////////////////////////////
// Row buffer geometry
////////////////////////////////////////
`define ROW_BUF_BRAM_DEPTH 1024
`define ROW_IDX_W $clog2(`ROW_BUF_BRAM_DEPTH)

// Pixel-sequence BRAM address and count width
`define SEQ_ADDR_W 12

////////////////////////////////////////
// Engine array
////////////////////////////////////////
`define NUM_AWE 4
`define NUM_CE_PER_AWE 2
`define NUM_CE (`NUM_AWE * `NUM_CE_PER_AWE)

// One 3x3 window takes this many sequence reads
`define WINDOW_NUM_CYCLES 6
`define SEQ_RD_LATENCY 3
`define PRIME_ROWS 3

`endif

//--- rtl/quad_ctrl_pkg.sv
`include "quad_ctrl_config.svh"

package quad_ctrl_pkg;

    ////////////////////////////////////////
    // Job FSM states
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE,
        PRIME_BUFFER,
        WAIT_PFB_LOAD,
        CE_ACTIVE,
        WAIT_JOB_DONE,
        SEND_COMPLETE
    } quad_state_t;

    // Row and column index into a row buffer
    typedef logic [`ROW_IDX_W-1:0] row_idx_t;

    typedef logic [`SEQ_ADDR_W-1:0] seq_addr_t;

    // One execute bit per convolution engine
    typedef logic [`NUM_CE-1:0] ce_mask_t;

    // Oldest physical row buffer of four
    typedef logic [1:0] gray_t;
    typedef logic [$clog2(`WINDOW_NUM_CYCLES)-1:0] win_cyc_t;

endpackage

//--- rtl/quad_job_fsm.sv
`timescale 1ns/10ps
`include "quad_ctrl_config.svh"

module quad_job_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  quad_ctrl_pkg::row_idx_t    num_expd_input_rows,
    input  logic                       job_start,
    input  logic                       job_complete_ack,
    input  logic                       pipeline_flushed,
    input  logic                       fetch_done,
    input  logic                       buf_empty,
    input  quad_ctrl_pkg::row_idx_t    input_row,
    input  logic                       pass_done,
    output quad_ctrl_pkg::quad_state_t state,
    output logic                       job_accept,
    output logic                       job_complete,
    output logic                       fetch_go,
    output logic                       read_enable,
    output logic                       pass_start,
    output logic                       advance_gray,
    output logic                       clear_gray
);

    // Where to resume once the fetched row has landed
    quad_ctrl_pkg::quad_state_t return_state;
    logic                       pass_live;
    logic                       rows_left;
    logic                       primed;

    assign rows_left = (input_row <= num_expd_input_rows);
    assign primed    = (input_row >= quad_ctrl_pkg::row_idx_t'(`PRIME_ROWS));

    ////////////////////////////////////////
    // Levels and strobes decoded from state
    ////////////////////////////////////////
    assign fetch_go    = (state == quad_ctrl_pkg::WAIT_PFB_LOAD);
    assign read_enable = (state == quad_ctrl_pkg::PRIME_BUFFER) ||
                         (state == quad_ctrl_pkg::CE_ACTIVE);
    assign clear_gray  = (state == quad_ctrl_pkg::IDLE) && job_start;

    // A pass begins once the freshly fetched row has drained
    assign pass_start   = (state == quad_ctrl_pkg::CE_ACTIVE) && !pass_live && buf_empty;
    assign advance_gray = (state == quad_ctrl_pkg::CE_ACTIVE) && pass_live && pass_done;

    ////////////////////////////////////////
    // Job sequencing
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= quad_ctrl_pkg::IDLE;
            return_state <= quad_ctrl_pkg::PRIME_BUFFER;
            pass_live    <= 1'b0;
            job_accept   <= 1'b0;
            job_complete <= 1'b0;
        end else begin
            job_accept <= 1'b0;
            case (state)
                quad_ctrl_pkg::IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= quad_ctrl_pkg::PRIME_BUFFER;
                    end
                end
                quad_ctrl_pkg::PRIME_BUFFER: begin
                    // Fill rows until the first window has three rows to work on
                    if (buf_empty && !primed) begin
                        return_state <= quad_ctrl_pkg::PRIME_BUFFER;
                        state        <= quad_ctrl_pkg::WAIT_PFB_LOAD;
                    end else if (buf_empty) begin
                        state <= quad_ctrl_pkg::CE_ACTIVE;
                    end
                end
                quad_ctrl_pkg::WAIT_PFB_LOAD: begin
                    if (fetch_done) begin
                        state <= return_state;
                    end
                end
                quad_ctrl_pkg::CE_ACTIVE: begin
                    if (pass_start) begin
                        pass_live <= 1'b1;
                    end
                    if (advance_gray) begin
                        pass_live <= 1'b0;
                        if (rows_left) begin
                            return_state <= quad_ctrl_pkg::CE_ACTIVE;
                            state        <= quad_ctrl_pkg::WAIT_PFB_LOAD;
                        end else begin
                            state <= quad_ctrl_pkg::WAIT_JOB_DONE;
                        end
                    end
                end
                quad_ctrl_pkg::WAIT_JOB_DONE: begin
                    if (pipeline_flushed) begin
                        job_complete <= 1'b1;
                        state        <= quad_ctrl_pkg::SEND_COMPLETE;
                    end
                end
                quad_ctrl_pkg::SEND_COMPLETE: begin
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= quad_ctrl_pkg::IDLE;
                    end
                end
                default: begin
                    state <= quad_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    // Accept only ever follows an idle cycle with the job taken
    a_accept_after_idle: assert property (@(posedge clk) disable iff (rst)
        job_accept |-> ($past(state) == quad_ctrl_pkg::IDLE) &&
                       (state == quad_ctrl_pkg::PRIME_BUFFER));

    a_complete_in_send: assert property (@(posedge clk) disable iff (rst)
        $rose(job_complete) |-> (state == quad_ctrl_pkg::SEND_COMPLETE) &&
                                $past(pipeline_flushed));

endmodule

//--- rtl/pfb_row_reader.sv
`timescale 1ns/10ps
`include "quad_ctrl_config.svh"

module pfb_row_reader (
    input  logic                    clk,
    input  logic                    rst,
    input  quad_ctrl_pkg::row_idx_t num_expd_input_cols,
    input  logic                    fetch_go,
    input  logic                    read_enable,
    input  logic                    job_fetch_ack,
    input  logic                    job_fetch_complete,
    input  logic                    job_complete_ack,
    output logic                    job_fetch_request,
    output logic                    job_fetch_in_progress,
    output logic                    fetch_done,
    output logic                    buf_empty,
    output logic                    pfb_rden,
    output quad_ctrl_pkg::row_idx_t input_row,
    output quad_ctrl_pkg::row_idx_t input_col,
    output logic                    next_row
);

    // One extra bit so a full row of depth pixels still fits
    logic [`ROW_IDX_W:0] pfb_count;
    logic                row_end;

    assign fetch_done = job_fetch_complete && job_fetch_in_progress;
    assign buf_empty  = (pfb_count == '0);
    assign pfb_rden   = read_enable && !buf_empty;
    assign row_end    = pfb_rden && (input_col == num_expd_input_cols);

    ////////////////////////////////////////
    // Fetch request and ack exchange
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            job_fetch_request     <= 1'b0;
            job_fetch_in_progress <= 1'b0;
        end else begin
            if (job_fetch_ack && job_fetch_request) begin
                job_fetch_request     <= 1'b0;
                job_fetch_in_progress <= 1'b1;
            end else if (fetch_go && !job_fetch_in_progress) begin
                job_fetch_request <= 1'b1;
            end
            if (fetch_done) begin
                job_fetch_in_progress <= 1'b0;
            end
        end
    end

    // Buffer occupancy, a full row per completed fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_count <= '0;
        end else if (fetch_done) begin
            pfb_count <= {1'b0, num_expd_input_cols} + 1'b1;
        end else if (pfb_rden) begin
            pfb_count <= pfb_count - 1'b1;
        end
    end

    ////////////////////////////////////////
    // Input row and column position
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            input_row <= '0;
            input_col <= '0;
            next_row  <= 1'b0;
        end else begin
            next_row <= row_end;
            if (job_complete_ack) begin
                input_row <= '0;
                input_col <= '0;
            end else if (row_end) begin
                input_col <= '0;
                input_row <= input_row + 1'b1;
            end else if (pfb_rden) begin
                input_col <= input_col + 1'b1;
            end
        end
    end

    // Occupancy and column together always make up one row
    a_read_in_row: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> (pfb_count + {1'b0, input_col} == {1'b0, num_expd_input_cols} + 1'b1));

    a_complete_in_progress: assert property (@(posedge clk) disable iff (rst)
        job_fetch_complete |-> job_fetch_in_progress);

endmodule

//--- rtl/pix_seq_reader.sv
`timescale 1ns/10ps
`include "quad_ctrl_config.svh"

module pix_seq_reader (
    input  logic                     clk,
    input  logic                     rst,
    input  quad_ctrl_pkg::seq_addr_t pix_seq_data_full_count,
    input  logic                     pass_start,
    output logic                     pix_seq_bram_rden,
    output quad_ctrl_pkg::seq_addr_t pix_seq_bram_rdaddr,
    output quad_ctrl_pkg::win_cyc_t  cycle_counter
);

    // Reads still owed in the current pass
    quad_ctrl_pkg::seq_addr_t seq_remaining;
    logic                     window_end;

    assign pix_seq_bram_rden = (seq_remaining != '0);
    assign window_end =
        (cycle_counter == quad_ctrl_pkg::win_cyc_t'(`WINDOW_NUM_CYCLES - 1));

    ////////////////////////////////////////
    // Sequence read stream
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_remaining <= '0;
        end else if (pass_start) begin
            seq_remaining <= pix_seq_data_full_count;
        end else if (pix_seq_bram_rden) begin
            seq_remaining <= seq_remaining - 1'b1;
        end
    end

    // Address restarts at 0 for every pass
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_seq_bram_rdaddr <= '0;
        end else if (pass_start) begin
            pix_seq_bram_rdaddr <= '0;
        end else if (pix_seq_bram_rden) begin
            pix_seq_bram_rdaddr <= pix_seq_bram_rdaddr + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Window cycle position
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_counter <= '0;
        end else if (pass_start) begin
            cycle_counter <= '0;
        end else if (pix_seq_bram_rden) begin
            if (window_end) begin
                cycle_counter <= '0;
            end else begin
                cycle_counter <= cycle_counter + 1'b1;
            end
        end
    end

    // FSM waits for the stream to drain before the next pass
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        pass_start |-> !pix_seq_bram_rden);

endmodule

//--- rtl/ce_dispatch.sv
`timescale 1ns/10ps
`include "quad_ctrl_config.svh"

module ce_dispatch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    seq_rden,
    input  logic                    advance_gray,
    input  logic                    clear_gray,
    output quad_ctrl_pkg::ce_mask_t ce_execute,
    output quad_ctrl_pkg::gray_t    gray_code,
    output logic                    pass_done
);

    // Read latency stages followed by the per-engine skew
    localparam int CHAIN_LEN = `SEQ_RD_LATENCY + `NUM_CE - 1;

    logic [CHAIN_LEN-1:0] exe_chain;
    logic                 last_lane_q;
    quad_ctrl_pkg::gray_t row_buf_cnt;

    ////////////////////////////////////////
    // Execute strobe chain
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            exe_chain   <= '0;
            last_lane_q <= 1'b0;
        end else begin
            exe_chain   <= {exe_chain[CHAIN_LEN-2:0], seq_rden};
            last_lane_q <= ce_execute[`NUM_CE-1];
        end
    end

    // Lane 0 sits at the end of the latency stages
    assign ce_execute = exe_chain[CHAIN_LEN-1 -: `NUM_CE];
    assign pass_done  = last_lane_q && !ce_execute[`NUM_CE-1];

    // Oldest row buffer, counted in binary
    always_ff @(posedge clk) begin
        if (rst) begin
            row_buf_cnt <= '0;
        end else if (clear_gray) begin
            row_buf_cnt <= '0;
        end else if (advance_gray) begin
            row_buf_cnt <= row_buf_cnt + 1'b1;
        end
    end

    assign gray_code = {row_buf_cnt[1], row_buf_cnt[1] ^ row_buf_cnt[0]};

    a_rotate_when_idle: assert property (@(posedge clk) disable iff (rst)
        advance_gray |-> (ce_execute == '0));

endmodule

//--- rtl/quad_bram_ctrl.sv
`timescale 1ns/10ps

module quad_bram_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  quad_ctrl_pkg::row_idx_t    num_expd_input_cols,
    input  quad_ctrl_pkg::row_idx_t    num_expd_input_rows,
    input  quad_ctrl_pkg::seq_addr_t   pix_seq_data_full_count,
    input  logic                       job_start,
    input  logic                       job_fetch_ack,
    input  logic                       job_fetch_complete,
    input  logic                       job_complete_ack,
    input  logic                       pipeline_flushed,
    output logic                       job_accept,
    output logic                       job_fetch_request,
    output logic                       job_fetch_in_progress,
    output logic                       job_complete,
    output quad_ctrl_pkg::quad_state_t state,
    output quad_ctrl_pkg::row_idx_t    input_row,
    output quad_ctrl_pkg::row_idx_t    input_col,
    output logic                       next_row,
    output logic                       pfb_rden,
    output logic                       pix_seq_bram_rden,
    output quad_ctrl_pkg::seq_addr_t   pix_seq_bram_rdaddr,
    output quad_ctrl_pkg::win_cyc_t    cycle_counter,
    output quad_ctrl_pkg::ce_mask_t    ce_execute,
    output quad_ctrl_pkg::gray_t       gray_code
);

    logic fetch_go;
    logic read_enable;
    logic fetch_done;
    logic buf_empty;
    logic pass_start;
    logic pass_done;
    logic advance_gray;
    logic clear_gray;

    ////////////////////////////////////////
    // Job sequencing
    ////////////////////////////////////////
    quad_job_fsm u_fsm (
        .clk                 (clk),
        .rst                 (rst),
        .num_expd_input_rows (num_expd_input_rows),
        .job_start           (job_start),
        .job_complete_ack    (job_complete_ack),
        .pipeline_flushed    (pipeline_flushed),
        .fetch_done          (fetch_done),
        .buf_empty           (buf_empty),
        .input_row           (input_row),
        .pass_done           (pass_done),
        .state               (state),
        .job_accept          (job_accept),
        .job_complete        (job_complete),
        .fetch_go            (fetch_go),
        .read_enable         (read_enable),
        .pass_start          (pass_start),
        .advance_gray        (advance_gray),
        .clear_gray          (clear_gray)
    );

    // Row fetch and prefetch buffer read-out
    pfb_row_reader u_pfb (
        .clk                   (clk),
        .rst                   (rst),
        .num_expd_input_cols   (num_expd_input_cols),
        .fetch_go              (fetch_go),
        .read_enable           (read_enable),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .job_complete_ack      (job_complete_ack),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .fetch_done            (fetch_done),
        .buf_empty             (buf_empty),
        .pfb_rden              (pfb_rden),
        .input_row             (input_row),
        .input_col             (input_col),
        .next_row              (next_row)
    );

    pix_seq_reader u_seq (
        .clk                     (clk),
        .rst                     (rst),
        .pix_seq_data_full_count (pix_seq_data_full_count),
        .pass_start              (pass_start),
        .pix_seq_bram_rden       (pix_seq_bram_rden),
        .pix_seq_bram_rdaddr     (pix_seq_bram_rdaddr),
        .cycle_counter           (cycle_counter)
    );

    // Engine strobes and row buffer rotation
    ce_dispatch u_ce (
        .clk          (clk),
        .rst          (rst),
        .seq_rden     (pix_seq_bram_rden),
        .advance_gray (advance_gray),
        .clear_gray   (clear_gray),
        .ce_execute   (ce_execute),
        .gray_code    (gray_code),
        .pass_done    (pass_done)
    );

endmodule

//--- test/tb_quad_bram_ctrl.sv
`timescale 1ns/10ps
`include "quad_ctrl_config.svh"

module tb_quad_bram_ctrl;

    localparam int NUM_JOBS = 5;
    localparam int HIST_TOP = `SEQ_RD_LATENCY + `NUM_CE;

    logic clk;
    logic rst;
    quad_ctrl_pkg::row_idx_t    num_expd_input_cols;
    quad_ctrl_pkg::row_idx_t    num_expd_input_rows;
    quad_ctrl_pkg::seq_addr_t   pix_seq_data_full_count;
    logic                       job_start;
    logic                       job_fetch_ack;
    logic                       job_fetch_complete;
    logic                       job_complete_ack;
    logic                       pipeline_flushed;
    logic                       job_accept;
    logic                       job_fetch_request;
    logic                       job_fetch_in_progress;
    logic                       job_complete;
    quad_ctrl_pkg::quad_state_t state;
    quad_ctrl_pkg::row_idx_t    input_row;
    quad_ctrl_pkg::row_idx_t    input_col;
    logic                       next_row;
    logic                       pfb_rden;
    logic                       pix_seq_bram_rden;
    quad_ctrl_pkg::seq_addr_t   pix_seq_bram_rdaddr;
    quad_ctrl_pkg::win_cyc_t    cycle_counter;
    quad_ctrl_pkg::ce_mask_t    ce_execute;
    quad_ctrl_pkg::gray_t       gray_code;

    integer seed;
    int     job_cols [NUM_JOBS];
    int     job_rows [NUM_JOBS];
    int     job_cnt [NUM_JOBS];
    int     cycle_limit;
    int     cycles;

    // Reference model state, updated at each falling edge
    logic [HIST_TOP:0]       hist;
    quad_ctrl_pkg::ce_mask_t exp_mask;
    int   m_pending;
    int   m_col;
    int   m_row;
    int   m_addr;
    int   m_passes;
    int   m_gcnt;
    int   i;
    logic exp_complete;
    logic cur_row_end;
    logic p_start, p_req, p_ack, p_inprog, p_fcmpl;
    logic p_row_end, p_rden, p_fell, p_flush, p_cack;

    quad_bram_ctrl UUT (.*);

    always #20 clk = ~clk;

    ////////////////////////////////////////
    // Checking helpers
    ////////////////////////////////////////
    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic bit_is(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic state_is(input string name, input quad_ctrl_pkg::quad_state_t got,
                            input quad_ctrl_pkg::quad_state_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic index_is(input string name, input quad_ctrl_pkg::row_idx_t got,
                            input quad_ctrl_pkg::row_idx_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic addr_is(input string name, input quad_ctrl_pkg::seq_addr_t got,
                           input quad_ctrl_pkg::seq_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic wcyc_is(input string name, input quad_ctrl_pkg::win_cyc_t got,
                           input quad_ctrl_pkg::win_cyc_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic mask_is(input string name, input quad_ctrl_pkg::ce_mask_t got,
                           input quad_ctrl_pkg::ce_mask_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic gray_is(input string name, input quad_ctrl_pkg::gray_t got,
                           input quad_ctrl_pkg::gray_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $unsigned($random(seed)) % (hi - lo + 1);
        return lo + r;
    endfunction

    // Oldest row buffer after n passes
    function automatic quad_ctrl_pkg::gray_t gray_step(input int n);
        case (n % 4)
            0: return 2'b00;
            1: return 2'b01;
            2: return 2'b11;
            default: return 2'b10;
        endcase
    endfunction

    // Inputs change just after the rising edge
    task automatic next_slot();
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////
    // Per-cycle reference model
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (rst) begin
            cycles       = 0;
            hist         = '0;
            m_pending    = 0;
            m_col        = 0;
            m_row        = 0;
            m_addr       = 0;
            m_passes     = 0;
            m_gcnt       = 0;
            exp_complete = 1'b0;
            {p_start, p_req, p_ack, p_inprog, p_fcmpl} = '0;
            {p_row_end, p_rden, p_fell, p_flush, p_cack} = '0;
        end else begin
            cycles++;
            if (cycles > cycle_limit) begin
                $display("Timeout: jobs did not finish within %0d cycles", cycle_limit);
                abort_run();
            end
            bit_is("job_accept", job_accept, p_start);

            // Fetch exchange
            if (p_req && p_ack) begin
                bit_is("job_fetch_request", job_fetch_request, 1'b0);
            end else if (p_req) begin
                bit_is("job_fetch_request", job_fetch_request, 1'b1);
            end
            if (p_inprog && p_fcmpl) begin
                bit_is("job_fetch_in_progress", job_fetch_in_progress, 1'b0);
                m_pending = int'(num_expd_input_cols) + 1;
            end else begin
                bit_is("job_fetch_in_progress", job_fetch_in_progress,
                       p_inprog || (p_req && p_ack));
            end

            // Buffer read-out walks the row
            index_is("input_row", input_row, quad_ctrl_pkg::row_idx_t'(m_row));
            bit_is("next_row", next_row, p_row_end);
            bit_is("pfb_rden", pfb_rden, m_pending != 0);
            cur_row_end = 1'b0;
            if (pfb_rden) begin
                index_is("input_col", input_col, quad_ctrl_pkg::row_idx_t'(m_col));
                m_pending--;
                if (m_col == int'(num_expd_input_cols)) begin
                    cur_row_end = 1'b1;
                    m_col = 0;
                    m_row++;
                end else begin
                    m_col++;
                end
            end
            if (job_complete_ack) begin
                m_row = 0;
                m_col = 0;
            end

            // Sequence stream of one pass
            if (pix_seq_bram_rden) begin
                if (!p_rden) begin
                    m_addr = 0;
                end
                addr_is("pix_seq_bram_rdaddr", pix_seq_bram_rdaddr,
                        quad_ctrl_pkg::seq_addr_t'(m_addr));
                wcyc_is("cycle_counter", cycle_counter,
                        quad_ctrl_pkg::win_cyc_t'(m_addr % `WINDOW_NUM_CYCLES));
                m_addr++;
            end else if (p_rden) begin
                addr_is("reads per pass", quad_ctrl_pkg::seq_addr_t'(m_addr),
                        pix_seq_data_full_count);
                m_passes++;
            end

            // Lane i trails the read enable by latency plus i
            hist = {hist[HIST_TOP-1:0], pix_seq_bram_rden};
            for (i = 0; i < `NUM_CE; i++) begin
                exp_mask[i] = hist[`SEQ_RD_LATENCY + i];
            end
            mask_is("ce_execute", ce_execute, exp_mask);

            if (p_start) begin
                m_gcnt = 0;
            end else if (p_fell) begin
                m_gcnt++;
            end
            gray_is("gray_code", gray_code, gray_step(m_gcnt));

            if (p_flush) begin
                exp_complete = 1'b1;
            end else if (p_cack) begin
                exp_complete = 1'b0;
                state_is("state", state, quad_ctrl_pkg::IDLE);
            end
            bit_is("job_complete", job_complete, exp_complete);
            if (job_complete) begin
                state_is("state", state, quad_ctrl_pkg::SEND_COMPLETE);
            end

            p_start   = (state == quad_ctrl_pkg::IDLE) && job_start;
            p_req     = job_fetch_request;
            p_ack     = job_fetch_ack;
            p_inprog  = job_fetch_in_progress;
            p_fcmpl   = job_fetch_complete;
            p_row_end = cur_row_end;
            p_rden    = pix_seq_bram_rden;
            p_fell    = hist[HIST_TOP] && !hist[HIST_TOP-1];
            p_flush   = (state == quad_ctrl_pkg::WAIT_JOB_DONE) && pipeline_flushed;
            p_cack    = job_complete_ack && job_complete;
        end
    end

    ////////////////////////////////////////
    // Outside fetch engine and job driver
    ////////////////////////////////////////
    task automatic serve_fetch();
        int ack_dly;
        int cmpl_dly;
        ack_dly  = rand_range(0, 5);
        cmpl_dly = rand_range(0, 5);
        repeat (ack_dly) begin
            @(negedge clk);
            bit_is("job_fetch_request", job_fetch_request, 1'b1);
        end
        next_slot();
        job_fetch_ack = 1'b1;
        next_slot();
        job_fetch_ack = 1'b0;
        repeat (cmpl_dly) next_slot();
        job_fetch_complete = 1'b1;
        next_slot();
        job_fetch_complete = 1'b0;
        @(negedge clk);
    endtask

    task automatic run_job(input int j);
        int passes_at_start;
        int ack_dly;
        next_slot();
        num_expd_input_cols     = quad_ctrl_pkg::row_idx_t'(job_cols[j]);
        num_expd_input_rows     = quad_ctrl_pkg::row_idx_t'(job_rows[j]);
        pix_seq_data_full_count = quad_ctrl_pkg::seq_addr_t'(job_cnt[j]);
        job_start               = 1'b1;
        passes_at_start         = m_passes;
        next_slot();
        job_start = 1'b0;
        @(negedge clk);
        bit_is("job_accept", job_accept, 1'b1);
        state_is("state", state, quad_ctrl_pkg::PRIME_BUFFER);
        gray_is("gray_code", gray_code, 2'b00);
        while (state != quad_ctrl_pkg::WAIT_JOB_DONE) begin
            if (job_fetch_request) begin
                serve_fetch();
            end else begin
                @(negedge clk);
            end
        end
        index_is("input_row", input_row, quad_ctrl_pkg::row_idx_t'(job_rows[j] + 1));

        // Completion must wait for the flush
        repeat (3) begin
            @(negedge clk);
            bit_is("job_complete", job_complete, 1'b0);
        end
        next_slot();
        if (m_passes - passes_at_start != job_rows[j] - 1) begin
            $display("Job %0d ran %0d window passes instead of %0d", j,
                     m_passes - passes_at_start, job_rows[j] - 1);
            abort_run();
        end
        pipeline_flushed = 1'b1;
        @(negedge clk);
        while (!job_complete) begin
            @(negedge clk);
        end
        next_slot();
        pipeline_flushed = 1'b0;
        ack_dly = rand_range(0, 5);
        repeat (ack_dly) begin
            @(negedge clk);
            bit_is("job_complete", job_complete, 1'b1);
        end
        next_slot();
        job_complete_ack = 1'b1;
        next_slot();
        job_complete_ack = 1'b0;
        @(negedge clk);
        state_is("state", state, quad_ctrl_pkg::IDLE);
        index_is("input_row", input_row, '0);
    endtask

    initial begin
        seed                    = 32'hba31_b4b9;
        clk                     = 1'b0;
        rst                     = 1'b1;
        num_expd_input_cols     = '0;
        num_expd_input_rows     = '0;
        pix_seq_data_full_count = '0;
        job_start               = 1'b0;
        job_fetch_ack           = 1'b0;
        job_fetch_complete      = 1'b0;
        job_complete_ack        = 1'b0;
        pipeline_flushed        = 1'b0;

        // Worst case per fetch and per pass with the largest delays
        cycle_limit = 100;
        for (int j = 0; j < NUM_JOBS; j++) begin
            job_cols[j] = rand_range(2, 9);
            job_rows[j] = rand_range(3, 7);
            job_cnt[j]  = rand_range(6, 30);
            cycle_limit += (job_rows[j] + 1) * (job_cols[j] + 22) +
                           (job_rows[j] - 1) * (job_cnt[j] + 16) + 40;
        end

        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        state_is("state", state, quad_ctrl_pkg::IDLE);
        bit_is("job_accept", job_accept, 1'b0);
        bit_is("job_fetch_request", job_fetch_request, 1'b0);
        bit_is("job_fetch_in_progress", job_fetch_in_progress, 1'b0);
        bit_is("job_complete", job_complete, 1'b0);
        bit_is("pfb_rden", pfb_rden, 1'b0);
        bit_is("pix_seq_bram_rden", pix_seq_bram_rden, 1'b0);
        bit_is("next_row", next_row, 1'b0);
        mask_is("ce_execute", ce_execute, '0);
        gray_is("gray_code", gray_code, 2'b00);

        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end
        repeat (4) @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+rtl
rtl/quad_ctrl_pkg.sv
rtl/quad_job_fsm.sv
rtl/pfb_row_reader.sv
rtl/pix_seq_reader.sv
rtl/ce_dispatch.sv
rtl/quad_bram_ctrl.sv
test/tb_quad_bram_ctrl.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_quad_bram_ctrl
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
